/* mips_slice_pkg.sv */
`default_nettype none

package mips_slice_pkg;

  // major opcodes, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    ADDI  = 6'b001000,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LW    = 6'b100011,
    SW    = 6'b101011
  } opcode_t;

  // r-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    F_JR  = 6'b001000,
    F_ADD = 6'b100000,
    F_SUB = 6'b100010,
    F_AND = 6'b100100,
    F_OR  = 6'b100101,
    F_XOR = 6'b100110,
    F_NOR = 6'b100111,
    F_SLT = 6'b101010
  } funct_t;

  // decoder class, refined by alu_control
  typedef enum logic [1:0] {
    ALU_ADD   = 2'd0,
    ALU_FIELD = 2'd1
  } alu_class_t;

  typedef enum logic [2:0] {
    FN_ADD = 3'd0,
    FN_SUB = 3'd1,
    FN_AND = 3'd2,
    FN_OR  = 3'd3,
    FN_XOR = 3'd4,
    FN_NOR = 3'd5,
    FN_SLT = 3'd6
  } alu_fn_t;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2,
    PC_REG    = 2'd3
  } pc_src_t;

  typedef enum logic [1:0] {
    DST_RT = 2'd0,
    DST_RD = 2'd1,
    DST_RA = 2'd2
  } dst_sel_t;

endpackage

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit import mips_slice_pkg::*; (
  input  opcode_t    opcode,
  input  funct_t     funct,
  input  logic       branch_eq,
  output pc_src_t    if_pc_source,
  output logic       rt_is_source,
  output logic       imm_zero_ext,
  output logic       alu_src_b,
  output logic       alu_rslt_src,
  output dst_sel_t   dst_reg_sel,
  output alu_class_t alu_class,
  output logic       mem_read,
  output logic       mem_write,
  output logic       mem_to_reg,
  output logic       reg_write
);

  logic memory_op;
  logic r_type_op;
  logic immediate_op;
  logic branch_op;
  logic jump_op;

  assign memory_op    = (opcode == LW) || (opcode == SW);
  assign r_type_op    = (opcode == RTYPE);
  assign branch_op    = (opcode == BEQ);
  assign jump_op      = (opcode == J) || (opcode == JAL);
  assign immediate_op = (opcode == ADDI) || (opcode == SLTI) || (opcode == ANDI) ||
                        (opcode == ORI) || (opcode == XORI);

  // rt is read as an operand, not used as a destination
  assign rt_is_source = r_type_op || branch_op || (opcode == SW);

  // logical immediates are zero extended, the rest sign extended
  assign imm_zero_ext = (opcode == ANDI) || (opcode == ORI) || (opcode == XORI);

  always_comb begin
    if_pc_source = PC_SEQ;
    alu_src_b    = 1'b0;
    alu_rslt_src = 1'b0;
    dst_reg_sel  = DST_RT;
    alu_class    = ALU_ADD;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    mem_to_reg   = 1'b0;
    reg_write    = 1'b0;

    if (memory_op) begin
      // base plus offset address
      alu_src_b  = 1'b1;
      mem_to_reg = 1'b1;
      if (opcode == LW) begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end else begin
        mem_write = 1'b1;
      end
    end else if (r_type_op) begin
      if (funct == F_JR) begin
        // jump to rs, nothing written back
        if_pc_source = PC_REG;
      end else begin
        dst_reg_sel = DST_RD;
        alu_class   = ALU_FIELD;
        reg_write   = 1'b1;
      end
    end else if (immediate_op) begin
      alu_src_b = 1'b1;
      alu_class = ALU_FIELD;
      reg_write = 1'b1;
    end else if (branch_op) begin
      if (branch_eq) begin
        if_pc_source = PC_BRANCH;
      end
    end else if (jump_op) begin
      if_pc_source = PC_JUMP;
      if (opcode == JAL) begin
        // link register gets pc plus 4
        dst_reg_sel  = DST_RA;
        alu_rslt_src = 1'b1;
        reg_write    = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* alu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_control import mips_slice_pkg::*; (
  input  alu_class_t alu_class,
  input  opcode_t    opcode,
  input  funct_t     funct,
  output alu_fn_t    alu_fn
);

  always_comb begin
    alu_fn = FN_ADD;
    if (alu_class == ALU_FIELD) begin
      if (opcode == RTYPE) begin
        case (funct)
          F_SUB:   alu_fn = FN_SUB;
          F_AND:   alu_fn = FN_AND;
          F_OR:    alu_fn = FN_OR;
          F_XOR:   alu_fn = FN_XOR;
          F_NOR:   alu_fn = FN_NOR;
          F_SLT:   alu_fn = FN_SLT;
          default: alu_fn = FN_ADD;
        endcase
      end else begin
        // immediate forms pick the function from the opcode
        case (opcode)
          SLTI:    alu_fn = FN_SLT;
          ANDI:    alu_fn = FN_AND;
          ORI:     alu_fn = FN_OR;
          XORI:    alu_fn = FN_XOR;
          default: alu_fn = FN_ADD;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import mips_slice_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_fn_t     alu_fn,
  output logic [31:0] result
);

  logic [31:0] sum;
  logic [31:0] diff;
  logic        less;

  assign sum  = a + b;
  assign diff = a - b;

  // signed compare
  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (alu_fn)
      FN_ADD: begin
        result = sum;
      end
      FN_SUB: begin
        result = diff;
      end
      FN_AND: begin
        result = a & b;
      end
      FN_OR: begin
        result = a | b;
      end
      FN_XOR: begin
        result = a ^ b;
      end
      FN_NOR: begin
        result = ~(a | b);
      end
      FN_SLT: begin
        result = {31'b0, less};
      end
      default: begin
        result = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [32];

  // r0 is hardwired to zero
  assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
  assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_en && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] addr,
  input  logic        wr_en,
  input  logic [31:0] wr_data,
  output logic [31:0] rd_data
);

  localparam int AW = $clog2(DMEM_DEPTH);

  logic [31:0]   mem [DMEM_DEPTH];
  logic [AW-1:0] idx;

  // word address wraps at the depth
  assign idx = AW'(addr[31:2] % DMEM_DEPTH);

  assign rd_data = mem[idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        mem[i] <= 32'd0;
      end
    end else if (wr_en) begin
      mem[idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* mips_slice.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_slice import mips_slice_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output logic [31:0] pc,
  output logic        retire_valid,
  output logic [4:0]  retire_dst,
  output logic [31:0] retire_data
);

  // decode stage
  opcode_t     id_opcode;
  funct_t      id_funct;
  logic [4:0]  id_rs_addr;
  logic [4:0]  id_rt_addr;
  logic [4:0]  id_rd_addr;
  logic [31:0] id_imm;
  logic [31:0] id_pc_plus4;
  logic [31:0] rf_rs_data;
  logic [31:0] rf_rt_data;
  logic [31:0] id_rs_val;
  logic [31:0] id_rt_val;
  logic [4:0]  id_dst;
  pc_src_t     if_pc_source;
  logic        rt_is_source;
  logic        imm_zero_ext;
  logic        alu_src_b;
  logic        alu_rslt_src;
  dst_sel_t    dst_reg_sel;
  alu_class_t  alu_class;
  logic        mem_read;
  logic        mem_write;
  logic        mem_to_reg;
  logic        reg_write;

  // execute stage
  logic        ex_valid;
  opcode_t     ex_opcode;
  funct_t      ex_funct;
  logic [31:0] ex_rs;
  logic [31:0] ex_rt;
  logic [31:0] ex_imm;
  logic [31:0] ex_pc_plus4;
  logic [4:0]  ex_dst;
  logic        ex_alu_src_b;
  logic        ex_alu_rslt_src;
  alu_class_t  ex_alu_class;
  logic        ex_mem_read;
  logic        ex_mem_write;
  logic        ex_mem_to_reg;
  logic        ex_reg_write;
  alu_fn_t     ex_alu_fn;
  logic [31:0] ex_alu_out;
  logic [31:0] ex_mem_data;
  logic [31:0] ex_result;

  // writeback stage
  logic        wb_valid;
  logic        wb_reg_write;
  logic [4:0]  wb_dst;
  logic [31:0] wb_result;

  logic ex_fwd_ok;
  logic wb_fwd_ok;

  assign id_opcode   = opcode_t'(instr[31:26]);
  assign id_funct    = funct_t'(instr[5:0]);
  assign id_rs_addr  = instr[25:21];
  assign id_rt_addr  = instr[20:16];
  assign id_rd_addr  = instr[15:11];
  assign id_pc_plus4 = pc + 32'd4;
  assign id_imm      = imm_zero_ext ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs_addr (id_rs_addr),
    .rt_addr (id_rt_addr),
    .rs_data (rf_rs_data),
    .rt_data (rf_rt_data),
    .wr_en   (wb_valid & wb_reg_write),
    .wr_addr (wb_dst),
    .wr_data (wb_result)
  );

  // forwarding, execute result wins over writeback
  assign ex_fwd_ok = ex_valid && ex_reg_write && (ex_dst != 5'd0);
  assign wb_fwd_ok = wb_valid && wb_reg_write && (wb_dst != 5'd0);

  assign id_rs_val = (ex_fwd_ok && (ex_dst == id_rs_addr)) ? ex_result :
                     (wb_fwd_ok && (wb_dst == id_rs_addr)) ? wb_result : rf_rs_data;
  assign id_rt_val = (ex_fwd_ok && (ex_dst == id_rt_addr)) ? ex_result :
                     (wb_fwd_ok && (wb_dst == id_rt_addr)) ? wb_result : rf_rt_data;

  control_unit u_control_unit (
    .opcode       (id_opcode),
    .funct        (id_funct),
    .branch_eq    (id_rs_val == id_rt_val),
    .if_pc_source (if_pc_source),
    .rt_is_source (rt_is_source),
    .imm_zero_ext (imm_zero_ext),
    .alu_src_b    (alu_src_b),
    .alu_rslt_src (alu_rslt_src),
    .dst_reg_sel  (dst_reg_sel),
    .alu_class    (alu_class),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_to_reg   (mem_to_reg),
    .reg_write    (reg_write)
  );

  // non-writers carry destination 0
  always_comb begin
    case (dst_reg_sel)
      DST_RD:  id_dst = id_rd_addr;
      DST_RA:  id_dst = 5'd31;
      default: id_dst = id_rt_addr;
    endcase
    if (!reg_write) begin
      id_dst = 5'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= 32'd0;
    end else if (instr_valid) begin
      case (if_pc_source)
        PC_BRANCH: pc <= id_pc_plus4 + {id_imm[29:0], 2'b00};
        PC_JUMP:   pc <= {id_pc_plus4[31:28], instr[25:0], 2'b00};
        PC_REG:    pc <= id_rs_val;
        default:   pc <= id_pc_plus4;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    ex_opcode       <= id_opcode;
    ex_funct        <= id_funct;
    ex_rs           <= id_rs_val;
    ex_rt           <= rt_is_source ? id_rt_val : 32'd0;
    ex_imm          <= id_imm;
    ex_pc_plus4     <= id_pc_plus4;
    ex_dst          <= id_dst;
    ex_alu_src_b    <= alu_src_b;
    ex_alu_rslt_src <= alu_rslt_src;
    ex_alu_class    <= alu_class;
    ex_mem_read     <= mem_read;
    ex_mem_write    <= mem_write;
    ex_mem_to_reg   <= mem_to_reg;
    ex_reg_write    <= reg_write;
  end

  alu_control u_alu_control (
    .alu_class (ex_alu_class),
    .opcode    (ex_opcode),
    .funct     (ex_funct),
    .alu_fn    (ex_alu_fn)
  );

  alu u_alu (
    .a      (ex_rs),
    .b      (ex_alu_src_b ? ex_imm : ex_rt),
    .alu_fn (ex_alu_fn),
    .result (ex_alu_out)
  );

  data_mem #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_data_mem (
    .clk     (clk),
    .rst     (rst),
    .addr    (ex_alu_out),
    .wr_en   (ex_valid & ex_mem_write),
    .wr_data (ex_rt),
    .rd_data (ex_mem_data)
  );

  // load data, link address or alu result
  assign ex_result = (ex_mem_to_reg && ex_mem_read) ? ex_mem_data :
                     ex_alu_rslt_src ? ex_pc_plus4 : ex_alu_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg_write <= ex_reg_write;
    wb_dst       <= ex_dst;
    wb_result    <= ex_result;
  end

  assign retire_valid = wb_valid;
  assign retire_dst   = wb_dst;
  assign retire_data  = wb_result;

endmodule

`default_nettype wire

/* tb_mips_slice.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips_slice import mips_slice_pkg::*;;

  localparam int MAX_ENTRIES = 64;
  localparam int RAND = -1;
  localparam int B2B = 0;
  localparam int GAP1 = 1;

  logic        clk = 1'b0;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        retire_valid;
  logic [4:0]  retire_dst;
  logic [31:0] retire_data;

  // stimulus and expected values, one row per instruction
  logic [31:0] tbl_instr [MAX_ENTRIES];
  logic [31:0] tbl_pc [MAX_ENTRIES];
  logic [4:0]  tbl_dst [MAX_ENTRIES];
  logic [31:0] tbl_data [MAX_ENTRIES];
  logic        tbl_chk_data [MAX_ENTRIES];
  int          tbl_gap [MAX_ENTRIES];
  int          n_entries = 0;

  int     issued_q [$];
  int     issue_idx;
  int     retired_count = 0;
  int     cycle_count = 0;
  int     timeout_limit;
  integer seed;
  logic   pc_pending = 1'b0;
  int     pc_idx;

  mips_slice #(
    .DMEM_DEPTH (64)
  ) dut0 (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_dst   (retire_dst),
    .retire_data  (retire_data)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] encode_r(input funct_t fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
    return {RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encode_i(input opcode_t op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encode_j(input opcode_t op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [31:0] exp_pc,
                           input logic [4:0] exp_dst, input logic [31:0] exp_data,
                           input logic chk_data, input int gap);
    tbl_instr[n_entries]    = word;
    tbl_pc[n_entries]       = exp_pc;
    tbl_dst[n_entries]      = exp_dst;
    tbl_data[n_entries]     = exp_data;
    tbl_chk_data[n_entries] = chk_data;
    tbl_gap[n_entries]      = gap;
    n_entries++;
  endtask

  task automatic build_table();
    // immediates, logical ones zero extended
    add_entry(encode_i(ADDI, 5'd1, 5'd0, 16'hfffb), 32'h04, 5'd1, 32'hffff_fffb, 1'b1, RAND);
    add_entry(encode_i(ANDI, 5'd2, 5'd1, 16'hf0f0), 32'h08, 5'd2, 32'h0000_f0f0, 1'b1, B2B);
    add_entry(encode_i(ORI, 5'd3, 5'd0, 16'h8001), 32'h0c, 5'd3, 32'h0000_8001, 1'b1, RAND);
    add_entry(encode_i(XORI, 5'd4, 5'd1, 16'hffff), 32'h10, 5'd4, 32'hffff_0004, 1'b1, RAND);
    add_entry(encode_i(SLTI, 5'd5, 5'd1, 16'hffff), 32'h14, 5'd5, 32'h1, 1'b1, RAND);
    add_entry(encode_i(SLTI, 5'd6, 5'd3, 16'hffff), 32'h18, 5'd6, 32'h0, 1'b1, RAND);
    // r-type
    add_entry(encode_i(ADDI, 5'd7, 5'd0, 16'd100), 32'h1c, 5'd7, 32'h64, 1'b1, RAND);
    add_entry(encode_r(F_ADD, 5'd8, 5'd7, 5'd1), 32'h20, 5'd8, 32'h5f, 1'b1, RAND);
    add_entry(encode_r(F_SUB, 5'd9, 5'd1, 5'd7), 32'h24, 5'd9, 32'hffff_ff97, 1'b1, RAND);
    add_entry(encode_r(F_AND, 5'd10, 5'd4, 5'd7), 32'h28, 5'd10, 32'h4, 1'b1, RAND);
    add_entry(encode_r(F_OR, 5'd11, 5'd2, 5'd3), 32'h2c, 5'd11, 32'hf0f1, 1'b1, RAND);
    add_entry(encode_r(F_XOR, 5'd12, 5'd4, 5'd2), 32'h30, 5'd12, 32'hffff_f0f4, 1'b1, RAND);
    add_entry(encode_r(F_NOR, 5'd13, 5'd2, 5'd3), 32'h34, 5'd13, 32'hffff_0f0e, 1'b1, RAND);
    add_entry(encode_r(F_SLT, 5'd14, 5'd9, 5'd7), 32'h38, 5'd14, 32'h1, 1'b1, RAND);
    add_entry(encode_r(F_SLT, 5'd15, 5'd7, 5'd1), 32'h3c, 5'd15, 32'h0, 1'b1, RAND);
    // r0 retires a value but still reads as zero right after
    add_entry(encode_r(F_ADD, 5'd0, 5'd7, 5'd7), 32'h40, 5'd0, 32'hc8, 1'b1, RAND);
    add_entry(encode_r(F_ADD, 5'd16, 5'd0, 5'd7), 32'h44, 5'd16, 32'h64, 1'b1, B2B);
    // dependency chains
    add_entry(encode_i(ADDI, 5'd17, 5'd0, 16'h10), 32'h48, 5'd17, 32'h10, 1'b1, RAND);
    add_entry(encode_i(ADDI, 5'd17, 5'd17, 16'h1), 32'h4c, 5'd17, 32'h11, 1'b1, B2B);
    add_entry(encode_r(F_ADD, 5'd18, 5'd17, 5'd17), 32'h50, 5'd18, 32'h22, 1'b1, B2B);
    add_entry(encode_r(F_SUB, 5'd19, 5'd18, 5'd17), 32'h54, 5'd19, 32'h11, 1'b1, B2B);
    add_entry(encode_i(ADDI, 5'd20, 5'd0, 16'h7), 32'h58, 5'd20, 32'h7, 1'b1, RAND);
    add_entry(encode_r(F_ADD, 5'd21, 5'd20, 5'd20), 32'h5c, 5'd21, 32'he, 1'b1, GAP1);
    add_entry(encode_r(F_XOR, 5'd22, 5'd21, 5'd20), 32'h60, 5'd22, 32'h9, 1'b1, GAP1);
    // memory, 64 words so byte address 0x148 aliases 0x48
    add_entry(encode_i(ADDI, 5'd23, 5'd0, 16'h40), 32'h64, 5'd23, 32'h40, 1'b1, RAND);
    add_entry(encode_i(ADDI, 5'd24, 5'd0, 16'h1234), 32'h68, 5'd24, 32'h1234, 1'b1, RAND);
    add_entry(encode_i(SW, 5'd24, 5'd23, 16'h8), 32'h6c, 5'd0, 32'h0, 1'b0, B2B);
    add_entry(encode_i(LW, 5'd25, 5'd23, 16'h8), 32'h70, 5'd25, 32'h1234, 1'b1, B2B);
    add_entry(encode_i(LW, 5'd26, 5'd0, 16'h148), 32'h74, 5'd26, 32'h1234, 1'b1, RAND);
    add_entry(encode_i(SW, 5'd7, 5'd0, 16'h204), 32'h78, 5'd0, 32'h0, 1'b0, RAND);
    add_entry(encode_i(LW, 5'd27, 5'd0, 16'h4), 32'h7c, 5'd27, 32'h64, 1'b1, RAND);
    // branches and jumps
    add_entry(encode_i(BEQ, 5'd25, 5'd24, 16'h2), 32'h88, 5'd0, 32'h0, 1'b0, RAND);
    add_entry(encode_i(BEQ, 5'd7, 5'd1, 16'h5), 32'h8c, 5'd0, 32'h0, 1'b0, RAND);
    add_entry(encode_i(BEQ, 5'd0, 5'd0, 16'hfffd), 32'h84, 5'd0, 32'h0, 1'b0, RAND);
    add_entry(encode_j(J, 26'h40), 32'h100, 5'd0, 32'h0, 1'b0, RAND);
    add_entry(encode_j(JAL, 26'h80), 32'h200, 5'd31, 32'h104, 1'b1, RAND);
    add_entry(encode_i(ADDI, 5'd29, 5'd0, 16'h300), 32'h204, 5'd29, 32'h300, 1'b1, RAND);
    add_entry(encode_r(F_JR, 5'd0, 5'd29, 5'd0), 32'h300, 5'd0, 32'h0, 1'b0, B2B);
    add_entry(encode_j(JAL, 26'h90), 32'h240, 5'd31, 32'h304, 1'b1, RAND);
    add_entry(encode_r(F_JR, 5'd0, 5'd31, 5'd0), 32'h304, 5'd0, 32'h0, 1'b0, B2B);
    add_entry(encode_i(ADDI, 5'd30, 5'd0, 16'h7), 32'h308, 5'd30, 32'h7, 1'b1, RAND);
    add_entry(encode_i(BEQ, 5'd20, 5'd30, 16'h4), 32'h31c, 5'd0, 32'h0, 1'b0, B2B);
    add_entry(encode_r(F_ADD, 5'd1, 5'd30, 5'd20), 32'h320, 5'd1, 32'he, 1'b1, RAND);
  endtask

  task automatic check_eq(input string what, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  initial begin : stimulus
    int gap;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'd0;
    seed        = 32'h1eb6_7578;
    build_table();
    timeout_limit = n_entries * 5 + 20;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      if (tbl_gap[i] >= 0) begin
        gap = tbl_gap[i];
      end else begin
        gap = $unsigned($random(seed)) % 3;
      end
      if (gap > 0) begin
        instr_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      instr_valid <= 1'b1;
      instr       <= tbl_instr[i];
      issue_idx = i;
      issued_q.push_back(i);
      @(posedge clk);
    end
    instr_valid <= 1'b0;
    while (retired_count < n_entries) begin
      @(negedge clk);
    end
    // a few idle cycles to catch stray retires
    repeat (3) @(posedge clk);
    $display("Test passed");
    $finish;
  end

  // outputs are sampled at the falling edge, away from the driving edge
  always @(negedge clk) begin : retire_monitor
    int idx;
    if (!rst) begin
      if (pc_pending) begin
        check_eq($sformatf("entry %0d pc", pc_idx), pc, tbl_pc[pc_idx]);
        pc_pending = 1'b0;
      end
      if (instr_valid) begin
        pc_pending = 1'b1;
        pc_idx     = issue_idx;
      end
      if (retire_valid) begin
        if (issued_q.size() == 0) begin
          abort_run("A result retired while no instruction was in flight.");
        end else begin
          idx = issued_q.pop_front();
          check_eq($sformatf("entry %0d retire_dst", idx), {27'd0, retire_dst},
                   {27'd0, tbl_dst[idx]});
          if (tbl_chk_data[idx]) begin
            check_eq($sformatf("entry %0d retire_data", idx), retire_data, tbl_data[idx]);
          end
          retired_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      abort_run("Timeout: not every instruction retired within the cycle limit.");
    end
  end

endmodule

`default_nettype wire

/* mips_slice.f */
mips_slice_pkg.sv
control_unit.sv
alu_control.sv
alu.sv
reg_file.sv
data_mem.sv
mips_slice.sv
tb_mips_slice.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_mips_slice
FILELIST  ?= mips_slice.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
